/* wishbone_pkg.sv */
// ******************************
// memory-side types for the L2 link
// data and address words plus the
// Wishbone classic master/slave structs
// import inside a module body, or use
// scoped names in port lists
// ******************************
`default_nettype none

package wishbone_pkg;

    // one bus word, a block moves one of these per beat
    typedef logic [63:0] data_t;

    // word address, not byte address
    typedef logic [31:0] addr_t;

    // master to slave, classic cycle
    // cyc frames the whole access, stb marks a live beat
    typedef struct packed {
        logic  cyc;
        logic  stb;
        // high for a write beat
        logic  we;
        addr_t adr;
        // write data, ignored by the slave when we is low
        data_t dat;
    } wb_m2s_t;

    // slave to master
    // ack is a single-cycle strobe, read data rides with it
    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

/* coherence_pkg.sv */
// ******************************
// bus-side types for the MESI bus
// opcodes, controller states and the
// per-cpu request/response and snoop
// structs; word types come from the
// memory-side package
// ******************************
`default_nettype none

package coherence_pkg;

    // bus transaction requested by a cache
    // BUS_NONE means the cache is not requesting
    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_RD,
        BUS_RDX,
        BUS_UPGR,
        BUS_WB
    } bus_op_t;

    // controller FSM
    typedef enum logic [3:0] {
        IDLE,
        GRANT,
        SNOOP,
        SNOOP_RESOLVE,
        RMEM,
        TRANSFER,
        INVALIDATE,
        WMEM
    } bus_state_t;

    // cache to controller
    // op and addr stay up until the last ready of the transaction
    typedef struct packed {
        bus_op_t             op;
        // block base address
        wishbone_pkg::addr_t addr;
        // current beat word, as requester (write-back) or supplier
        wishbone_pkg::data_t store;
    } cpu_req_t;

    // controller to cache
    typedef struct packed {
        // one pulse per beat
        logic                ready;
        // valid together with ready
        wishbone_pkg::data_t load;
        // valid with the final ready of a read
        logic                exclusive;
    } cpu_rsp_t;

    // snoop broadcast, one cycle wide
    typedef struct packed {
        logic                valid;
        wishbone_pkg::addr_t addr;
        // drop the copy of addr
        logic                inv;
    } snoop_req_t;

    // snoop answer, given the cycle after valid
    typedef struct packed {
        logic hit;
    } snoop_rsp_t;

endpackage

`default_nettype wire

/* rr_arbiter.sv */
// ******************************
// round-robin requester select
// grant is one-hot and combinational,
// the pointer moves past the winner
// on the edge after advance
// ******************************
`default_nettype none

module rr_arbiter #(
    parameter int CPUS = 4
) (
    input  logic            CLK,
    input  logic            nRST,
    input  logic [CPUS-1:0] req,
    input  logic            advance,
    output logic [CPUS-1:0] grant
);

    localparam int IDW = (CPUS > 1) ? $clog2(CPUS) : 1;

    // first cpu to look at
    logic [IDW-1:0] ptr;
    // index of the current winner
    logic [IDW-1:0] grant_id;

    // scan from ptr upward, wrapping, first requester wins
    always_comb begin
        int   idx;
        logic found;
        grant    = '0;
        grant_id = ptr;
        found    = 1'b0;
        for (int k = 0; k < CPUS; k++) begin
            idx = int'(ptr) + k;
            if (idx >= CPUS)
                idx = idx - CPUS;
            if (!found && req[idx]) begin
                found       = 1'b1;
                grant[idx]  = 1'b1;
                grant_id    = IDW'(idx);
            end
        end
    end

    // rotate past the cpu that was just served
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ptr <= '0;
        end else if (advance && (|req)) begin
            if (grant_id == IDW'(CPUS - 1))
                ptr <= '0;
            else
                ptr <= grant_id + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* bus_ctrl.sv */
// ******************************
// MESI snooping bus controller
// one transaction at a time: snoop,
// invalidate, cache-to-cache transfer,
// L2 read and write-back over a
// Wishbone classic master port
// ******************************
`default_nettype none

module bus_ctrl #(
    parameter int CPUS        = 4,
    parameter int BLOCK_WORDS = 2
) (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  coherence_pkg::cpu_req_t   [CPUS-1:0] cpu_req,
    output coherence_pkg::cpu_rsp_t   [CPUS-1:0] cpu_rsp,
    output coherence_pkg::snoop_req_t [CPUS-1:0] snoop_req,
    input  coherence_pkg::snoop_rsp_t [CPUS-1:0] snoop_rsp,
    input  logic                      [CPUS-1:0] grant,
    output logic                                 advance,
    output wishbone_pkg::wb_m2s_t                wb_out,
    input  wishbone_pkg::wb_s2m_t                wb_in
);

    import coherence_pkg::*;
    import wishbone_pkg::*;

    localparam int IDW = (CPUS > 1) ? $clog2(CPUS) : 1;
    localparam int CW  = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;

    bus_state_t     state, state_n;
    bus_op_t        cur_op;
    // grant as seen in IDLE
    logic [CPUS-1:0] grant_q;
    logic [IDW-1:0] req_id;
    logic [IDW-1:0] sup_id;
    // some other cache answered hit
    logic           hit_any;
    logic [CW-1:0]  beat;
    // idle cycle between memory beats
    logic           gap;
    addr_t          blk_addr;
    // supplier words kept for the write-back after a shared read
    data_t          blk_buf [BLOCK_WORDS];

    logic [IDW-1:0] grant_id;
    logic [IDW-1:0] hit_id;
    logic           hit_now;
    logic           last_beat;
    logic           mem_phase;
    logic           beat_done;
    logic           excl_flag;

    assign last_beat = (beat == CW'(BLOCK_WORDS - 1));
    assign mem_phase = (state == RMEM) || (state == WMEM);
    // L2 acked the live beat
    assign beat_done = mem_phase && !gap && wb_in.ack;
    // E on a read nobody else holds, M-bound on read-exclusive
    assign excl_flag = (cur_op == BUS_RDX) || !hit_any;

    // one-hot grant to index
    always_comb begin
        grant_id = '0;
        for (int i = CPUS - 1; i >= 0; i--) begin
            if (grant_q[i])
                grant_id = IDW'(i);
        end
    end

    // lowest-index hitting cache, requester excluded
    always_comb begin
        hit_id  = '0;
        hit_now = 1'b0;
        for (int i = CPUS - 1; i >= 0; i--) begin
            if (snoop_rsp[i].hit && (i != int'(req_id))) begin
                hit_id  = IDW'(i);
                hit_now = 1'b1;
            end
        end
    end

    // next state
    always_comb begin
        state_n = state;
        case (state)
            IDLE:          if (|grant) state_n = GRANT;
            GRANT:         state_n = (cpu_req[grant_id].op == BUS_WB) ? WMEM : SNOOP;
            SNOOP:         state_n = SNOOP_RESOLVE;
            SNOOP_RESOLVE: begin
                if (cur_op == BUS_UPGR)
                    state_n = INVALIDATE;
                else if (hit_now)
                    state_n = TRANSFER;
                else
                    state_n = RMEM;
            end
            INVALIDATE:    state_n = IDLE;
            TRANSFER: begin
                // shared read still owes L2 the block
                if (last_beat)
                    state_n = (cur_op == BUS_RD) ? WMEM : IDLE;
            end
            RMEM, WMEM:    if (beat_done && last_beat) state_n = IDLE;
            default:       state_n = IDLE;
        endcase
    end

    // control registers
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            cur_op  <= BUS_NONE;
            grant_q <= '0;
            req_id  <= '0;
            sup_id  <= '0;
            hit_any <= 1'b0;
            beat    <= '0;
            gap     <= 1'b0;
        end else begin
            state <= state_n;
            case (state)
                IDLE: grant_q <= grant;
                GRANT: begin
                    req_id  <= grant_id;
                    cur_op  <= cpu_req[grant_id].op;
                    hit_any <= 1'b0;
                    beat    <= '0;
                    gap     <= 1'b0;
                end
                SNOOP_RESOLVE: begin
                    sup_id  <= hit_id;
                    hit_any <= hit_now;
                end
                TRANSFER: beat <= last_beat ? '0 : beat + 1'b1;
                RMEM, WMEM: begin
                    if (gap) begin
                        gap <= 1'b0;
                    end else if (beat_done) begin
                        gap  <= !last_beat;
                        beat <= last_beat ? '0 : beat + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // block base and transfer buffer
    always_ff @(posedge CLK) begin
        if (state == GRANT)
            blk_addr <= cpu_req[grant_id].addr;
        if (state == TRANSFER)
            blk_buf[beat] <= cpu_req[sup_id].store;
    end

    // cpu, snoop and Wishbone outputs
    always_comb begin
        advance = (state == IDLE) && (|grant);
        cpu_rsp   = '0;
        snoop_req = '0;
        wb_out    = '0;
        case (state)
            SNOOP: begin
                // everyone but the requester
                for (int i = 0; i < CPUS; i++) begin
                    snoop_req[i].valid = (i != int'(req_id));
                    snoop_req[i].addr  = blk_addr;
                    snoop_req[i].inv   = (i != int'(req_id)) &&
                                         ((cur_op == BUS_RDX) || (cur_op == BUS_UPGR));
                end
            end
            INVALIDATE: cpu_rsp[req_id].ready = 1'b1;
            TRANSFER: begin
                // requester and supplier step together
                cpu_rsp[sup_id].ready     = 1'b1;
                cpu_rsp[req_id].ready     = 1'b1;
                cpu_rsp[req_id].load      = cpu_req[sup_id].store;
                cpu_rsp[req_id].exclusive = last_beat && excl_flag;
            end
            RMEM: begin
                wb_out.cyc = 1'b1;
                wb_out.stb = !gap;
                wb_out.adr = blk_addr + addr_t'(beat);
                cpu_rsp[req_id].ready     = beat_done;
                cpu_rsp[req_id].load      = wb_in.dat;
                cpu_rsp[req_id].exclusive = beat_done && last_beat && excl_flag;
            end
            WMEM: begin
                wb_out.cyc = 1'b1;
                wb_out.stb = !gap;
                wb_out.we  = 1'b1;
                wb_out.adr = blk_addr + addr_t'(beat);
                // eviction data from the requester, else the buffered block
                wb_out.dat = (cur_op == BUS_WB) ? cpu_req[req_id].store : blk_buf[beat];
                cpu_rsp[req_id].ready = beat_done && (cur_op == BUS_WB);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* l2_mem.sv */
// ******************************
// shared L2 word memory
// Wishbone classic slave, acks a
// fixed number of wait states after
// stb rises; storage clears on reset
// ******************************
`default_nettype none

module l2_mem #(
    parameter int L2_WAIT       = 2,
    parameter int L2_DEPTH_LOG2 = 8
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  wishbone_pkg::wb_m2s_t wb_in,
    output wishbone_pkg::wb_s2m_t wb_out
);

    import wishbone_pkg::*;

    localparam int DEPTH = 1 << L2_DEPTH_LOG2;
    localparam int WW    = (L2_WAIT > 0) ? $clog2(L2_WAIT + 1) : 1;

    data_t mem [DEPTH];

    // cycles of stb seen so far in this beat
    logic [WW-1:0]            wait_cnt;
    logic                     access;
    logic                     ack;
    logic [L2_DEPTH_LOG2-1:0] index;

    assign access = wb_in.cyc && wb_in.stb;
    // upper address bits fold onto the array
    assign index  = wb_in.adr[L2_DEPTH_LOG2-1:0];
    // with zero wait states this acks in the first stb cycle
    assign ack    = access && (wait_cnt == WW'(L2_WAIT));

    // wait-state counter
    // restarts whenever stb drops or the beat completes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (access && !ack) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // storage
    // never-written blocks read back as zero
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
        end else if (ack && wb_in.we) begin
            mem[index] <= wb_in.dat;
        end
    end

    // read data only qualifies with ack
    always_comb begin
        wb_out.ack = ack;
        wb_out.dat = ack ? mem[index] : '0;
    end

endmodule

`default_nettype wire

/* coherent_bus_top.sv */
// ******************************
// coherent bus top level
// arbiter, bus controller and L2;
// caches attach on the per-cpu arrays
// ******************************
`default_nettype none

module coherent_bus_top #(
    parameter int CPUS          = 4,
    parameter int BLOCK_WORDS   = 2,
    parameter int L2_WAIT       = 2,
    parameter int L2_DEPTH_LOG2 = 8
) (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  coherence_pkg::cpu_req_t   [CPUS-1:0] cpu_req,
    output coherence_pkg::cpu_rsp_t   [CPUS-1:0] cpu_rsp,
    output coherence_pkg::snoop_req_t [CPUS-1:0] snoop_req,
    input  coherence_pkg::snoop_rsp_t [CPUS-1:0] snoop_rsp
);

    import coherence_pkg::*;
    import wishbone_pkg::*;

    logic [CPUS-1:0] arb_req;
    logic [CPUS-1:0] arb_grant;
    logic            arb_advance;
    wb_m2s_t         wb_m2s;
    wb_s2m_t         wb_s2m;

    // a cpu requests whenever it shows an opcode
    for (genvar g = 0; g < CPUS; g++) begin : g_req
        assign arb_req[g] = (cpu_req[g].op != BUS_NONE);
    end

    rr_arbiter #(
        .CPUS (CPUS)
    ) arb_i (
        .CLK     (CLK),
        .nRST    (nRST),
        .req     (arb_req),
        .advance (arb_advance),
        .grant   (arb_grant)
    );

    bus_ctrl #(
        .CPUS        (CPUS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) ctrl_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .snoop_req (snoop_req),
        .snoop_rsp (snoop_rsp),
        .grant     (arb_grant),
        .advance   (arb_advance),
        .wb_out    (wb_m2s),
        .wb_in     (wb_s2m)
    );

    l2_mem #(
        .L2_WAIT       (L2_WAIT),
        .L2_DEPTH_LOG2 (L2_DEPTH_LOG2)
    ) l2_i (
        .CLK    (CLK),
        .nRST   (nRST),
        .wb_in  (wb_m2s),
        .wb_out (wb_s2m)
    );

endmodule

`default_nettype wire

/* coherent_bus_assertions.sv */
// ******************************
// protocol checks for the bus
// controller, bound into bus_ctrl;
// covers Wishbone, snoop and ready
// ******************************
`default_nettype none

module coherent_bus_assertions #(
    parameter int CPUS = 4,
    parameter int IDW  = 2
) (
    input logic                                 CLK,
    input logic                                 nRST,
    input coherence_pkg::bus_state_t            state,
    input logic                      [IDW-1:0]  req_id,
    input coherence_pkg::cpu_rsp_t   [CPUS-1:0] cpu_rsp,
    input coherence_pkg::snoop_req_t [CPUS-1:0] snoop_req,
    input wishbone_pkg::wb_m2s_t                wb_out,
    input wishbone_pkg::wb_s2m_t                wb_in
);

    timeunit 1ns;
    timeprecision 1ps;

    import coherence_pkg::*;

    // failed checks so far, read by the testbench at the end
    int unsigned     fail_cnt = 0;
    logic [CPUS-1:0] ready_vec;

    always_comb begin
        for (int i = 0; i < CPUS; i++)
            ready_vec[i] = cpu_rsp[i].ready;
    end

    // a live beat only inside a cycle
    stb_inside_cyc: assert property (@(posedge CLK) disable iff (!nRST)
        wb_out.stb |-> wb_out.cyc)
        else begin
            $error("Wishbone stb high while cyc is low");
            fail_cnt++;
        end

    // master holds the beat until the slave acks
    wb_hold_until_ack: assert property (@(posedge CLK) disable iff (!nRST)
        (wb_out.stb && !wb_in.ack) |=>
            (wb_out.stb && $stable(wb_out.adr) && $stable(wb_out.we) &&
             $stable(wb_out.dat)))
        else begin
            $error("Wishbone signals changed before ack");
            fail_cnt++;
        end

    // the requester never snoops itself
    no_self_snoop: assert property (@(posedge CLK) disable iff (!nRST)
        !snoop_req[req_id].valid)
        else begin
            $error("snoop valid sent to the requesting cpu");
            fail_cnt++;
        end

    // one beat owner, except the requester/supplier pair in TRANSFER
    single_ready: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(ready_vec) || ((state == TRANSFER) && ($countones(ready_vec) == 2)))
        else begin
            $error("ready pulsed to too many cpus in one cycle");
            fail_cnt++;
        end

endmodule

bind bus_ctrl coherent_bus_assertions #(
    .CPUS (CPUS),
    .IDW  (IDW)
) asrt_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .state     (state),
    .req_id    (req_id),
    .cpu_rsp   (cpu_rsp),
    .snoop_req (snoop_req),
    .wb_out    (wb_out),
    .wb_in     (wb_in)
);

`default_nettype wire

/* tb_coherent_bus.sv */
// ******************************
// directed testbench for the MESI
// bus top level; models the caches
// at the per-cpu ports, mirrors L2
// in a scoreboard and runs five tests
// ******************************
`default_nettype none

module tb_coherent_bus;

    timeunit 1ns;
    timeprecision 1ps;

    import coherence_pkg::*;
    import wishbone_pkg::*;

    localparam int CPUS      = 4;
    localparam int BW        = 2;
    localparam int CYCLE_NS  = 100;
    localparam int NUM_TESTS = 5;
    // block bases inside the 256-word L2
    localparam addr_t ADDR_A = 32'h10;
    localparam addr_t ADDR_B = 32'h24;
    localparam addr_t ADDR_C = 32'h38;
    localparam addr_t ADDR_D = 32'h52;
    localparam addr_t ADDR_E = 32'h60;

    logic                   CLK;
    logic                   nRST;
    cpu_req_t   [CPUS-1:0]  cpu_req;
    cpu_rsp_t   [CPUS-1:0]  cpu_rsp;
    snoop_req_t [CPUS-1:0]  snoop_req;
    snoop_rsp_t [CPUS-1:0]  snoop_rsp;

    // cache model state per cpu
    data_t words [CPUS][BW];
    data_t loads [CPUS][BW];
    int    beats [CPUS];
    int    done_cnt [CPUS];
    int    ready_total [CPUS];
    int    inv_cnt [CPUS];
    addr_t inv_addr [CPUS];
    addr_t hold_addr [CPUS];
    bit    hit_flag [CPUS];
    bit    excl [CPUS];
    // cpu index of each finished transaction in order
    int    done_q [$];
    // round-robin pointer just past the last served cpu
    int    rr_next = 0;
    // L2 mirror where missing entries read as zero
    data_t l2_ref [addr_t];
    int    seed = 32'h111f_96fd;
    int    data_errs = 0;
    int    flag_errs = 0;

    coherent_bus_top dut_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .snoop_req (snoop_req),
        .snoop_rsp (snoop_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #(CYCLE_NS / 2) CLK = ~CLK;
    end

    // cache models answer snoops, capture beats and step store
    always @(posedge CLK) begin : cache_model
        int cnt;
        bit last;
        for (int i = 0; i < CPUS; i++) begin
            if (snoop_req[i].valid) begin
                snoop_rsp[i].hit <= hit_flag[i] && (snoop_req[i].addr == hold_addr[i]);
                if (snoop_req[i].inv) begin
                    inv_cnt[i]++;
                    inv_addr[i] = snoop_req[i].addr;
                    hit_flag[i] = 1'b0;
                end
            end else begin
                snoop_rsp[i].hit <= 1'b0;
            end
            if (cpu_rsp[i].ready) begin
                ready_total[i]++;
                cnt  = beats[i] + 1;
                last = 1'b0;
                // a cpu with an opcode up is the requester and otherwise the supplier
                if (cpu_req[i].op != BUS_NONE) begin
                    loads[i][beats[i]] = cpu_rsp[i].load;
                    last = (cpu_req[i].op == BUS_UPGR) || (cnt == BW);
                    if (last) begin
                        excl[i] = cpu_rsp[i].exclusive;
                        cpu_req[i].op <= BUS_NONE;
                        done_cnt[i]++;
                        done_q.push_back(i);
                        rr_next = (i + 1) % CPUS;
                    end
                end
                beats[i] = (last || cnt >= BW) ? 0 : cnt;
                cpu_req[i].store <= words[i][beats[i]];
            end
        end
    end

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            data_errs++;
            $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("** Error at %0t ns: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic data_t ref_word(input addr_t a);
        if (l2_ref.exists(a))
            return l2_ref[a];
        return '0;
    endfunction

    task automatic fill_block(input int cpu);
        for (int k = 0; k < BW; k++)
            words[cpu][k] = {$random(seed), $random(seed)};
    endtask

    // cache takes a valid copy and will answer hit
    task automatic hold_block(input int cpu, input addr_t addr);
        fill_block(cpu);
        hit_flag[cpu]  = 1'b1;
        hold_addr[cpu] = addr;
        @(posedge CLK);
        cpu_req[cpu].store <= words[cpu][0];
    endtask

    task automatic request(input int cpu, input bus_op_t op, input addr_t addr);
        @(posedge CLK);
        cpu_req[cpu].op    <= op;
        cpu_req[cpu].addr  <= addr;
        cpu_req[cpu].store <= words[cpu][0];
    endtask

    task automatic await_done(input int cpu, input int target);
        do
            @(negedge CLK);
        while (done_cnt[cpu] < target);
    endtask

    task automatic issue(input int cpu, input bus_op_t op, input addr_t addr);
        int target;
        target = done_cnt[cpu] + 1;
        request(cpu, op, addr);
        await_done(cpu, target);
    endtask

    task automatic expect_l2_block(input int cpu, input addr_t addr, input string what);
        for (int k = 0; k < BW; k++)
            check_data(loads[cpu][k], ref_word(addr + k), what);
    endtask

    task automatic expect_cache_block(input int cpu, input int sup, input string what);
        for (int k = 0; k < BW; k++)
            check_data(loads[cpu][k], words[sup][k], what);
    endtask

    task automatic wb_then_read_miss();
        fill_block(1);
        for (int k = 0; k < BW; k++)
            l2_ref[ADDR_A + k] = words[1][k];
        issue(1, BUS_WB, ADDR_A);
        issue(2, BUS_RD, ADDR_A);
        expect_l2_block(2, ADDR_A, "read miss after write-back");
        check_bit(excl[2], 1'b1, "read miss exclusive");
    endtask

    task automatic read_snoop_hit();
        int inv_before;
        hold_block(3, ADDR_B);
        // a shared read writes the supplied block back to L2
        for (int k = 0; k < BW; k++)
            l2_ref[ADDR_B + k] = words[3][k];
        inv_before = inv_cnt[0] + inv_cnt[1] + inv_cnt[2] + inv_cnt[3];
        issue(0, BUS_RD, ADDR_B);
        expect_cache_block(0, 3, "cache-to-cache read data");
        check_bit(excl[0], 1'b0, "shared read exclusive");
        check_bit(inv_cnt[0] + inv_cnt[1] + inv_cnt[2] + inv_cnt[3] != inv_before,
                  1'b0, "inv seen on a plain read");
        // silent eviction of the clean copy
        hit_flag[3] = 1'b0;
        issue(1, BUS_RD, ADDR_B);
        expect_l2_block(1, ADDR_B, "L2 copy after shared read");
        check_bit(excl[1], 1'b1, "read miss exclusive");
    endtask

    task automatic read_exclusive();
        int inv1;
        int inv2;
        hold_block(1, ADDR_C);
        hold_block(2, ADDR_C);
        inv1 = inv_cnt[1];
        inv2 = inv_cnt[2];
        issue(0, BUS_RDX, ADDR_C);
        check_bit(inv_cnt[1] > inv1, 1'b1, "cpu 1 inv on read-exclusive");
        check_bit(inv_cnt[2] > inv2, 1'b1, "cpu 2 inv on read-exclusive");
        check_data(data_t'(inv_addr[1]), data_t'(ADDR_C), "inv address");
        // lowest hitting index supplies
        expect_cache_block(0, 1, "read-exclusive data");
        check_bit(excl[0], 1'b1, "read-exclusive exclusive");
        issue(3, BUS_RD, ADDR_D);
        expect_l2_block(3, ADDR_D, "untouched block");
        check_bit(excl[3], 1'b1, "read miss exclusive");
    endtask

    task automatic upgrade();
        int inv_before [CPUS];
        int ready_before;
        fill_block(0);
        for (int k = 0; k < BW; k++)
            l2_ref[ADDR_E + k] = words[0][k];
        issue(0, BUS_WB, ADDR_E);
        hold_block(1, ADDR_E);
        hold_block(3, ADDR_E);
        inv_before   = inv_cnt;
        ready_before = ready_total[2];
        issue(2, BUS_UPGR, ADDR_E);
        repeat (4) @(negedge CLK);
        for (int i = 0; i < CPUS; i++) begin
            if (i != 2) begin
                check_bit(inv_cnt[i] > inv_before[i], 1'b1, "inv on upgrade");
                check_data(data_t'(inv_addr[i]), data_t'(ADDR_E), "upgrade inv address");
            end
        end
        check_bit(inv_cnt[2] != inv_before[2], 1'b0, "requester invalidated");
        check_bit(ready_total[2] - ready_before == 1, 1'b1, "single ready on upgrade");
        issue(0, BUS_RD, ADDR_E);
        expect_l2_block(0, ADDR_E, "L2 after upgrade");
    endtask

    task automatic arbitration();
        int t0;
        int t2;
        int first;
        done_q.delete();
        t0 = done_cnt[0] + 1;
        t2 = done_cnt[2] + 1;
        // first of cpus 0 and 2 at or after the pointer with wrap
        first = ((rr_next > 0) && (rr_next <= 2)) ? 2 : 0;
        @(posedge CLK);
        cpu_req[0].op   <= BUS_RD;
        cpu_req[0].addr <= ADDR_A;
        cpu_req[2].op   <= BUS_RD;
        cpu_req[2].addr <= ADDR_B;
        await_done(0, t0);
        expect_l2_block(0, ADDR_A, "cpu 0 first read");
        // cpu 0 asks again right away
        request(0, BUS_RD, ADDR_E);
        await_done(2, t2);
        expect_l2_block(2, ADDR_B, "cpu 2 read");
        await_done(0, t0 + 1);
        expect_l2_block(0, ADDR_E, "cpu 0 second read");
        check_bit(done_q.size() == 3, 1'b1, "three completions");
        check_bit((done_q.size() == 3) && (done_q[0] == first), 1'b1,
                  "round-robin winner of the simultaneous requests");
        check_bit((done_q.size() == 3) && (done_q[2] == 0), 1'b1,
                  "cpu 2 served before cpu 0 second request");
    endtask

    // watchdog allows about 400 cycles per test
    initial begin
        #(CYCLE_NS * 400 * NUM_TESTS);
        $display("timeout: tests did not finish within %0d cycles", 400 * NUM_TESTS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int asrt_errs;
        nRST      = 1'b0;
        cpu_req   = '0;
        snoop_rsp = '0;
        for (int i = 0; i < CPUS; i++) begin
            beats[i]       = 0;
            done_cnt[i]    = 0;
            ready_total[i] = 0;
            inv_cnt[i]     = 0;
            hit_flag[i]    = 1'b0;
            for (int k = 0; k < BW; k++)
                words[i][k] = '0;
        end
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        repeat (2) @(negedge CLK);
        wb_then_read_miss();
        read_snoop_hit();
        read_exclusive();
        upgrade();
        arbitration();
        repeat (10) @(negedge CLK);
        asrt_errs = dut_i.ctrl_i.asrt_i.fail_cnt;
        $display("errors: %0d data, %0d flag, %0d assertion", data_errs, flag_errs, asrt_errs);
        if (data_errs + flag_errs + asrt_errs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
wishbone_pkg.sv
coherence_pkg.sv
rr_arbiter.sv
bus_ctrl.sv
l2_mem.sv
coherent_bus_top.sv
coherent_bus_assertions.sv
tb_coherent_bus.sv
